// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_ifu_err_dp \
		-f build.f -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
ifu_err_pkg.sv
ifu_err_tag_check.sv
ifu_err_addr_bank.sv
ifu_err_asi_read.sv
ifu_err_dp.sv
tb_ifu_err_dp.sv

// File: ifu_err_addr_bank.sv
// Stages the error sources and keeps one error address register per
// thread, each loaded from the source chosen by its eadr_sel entry.
`default_nettype none
`timescale 1ns/10ps

module ifu_err_addr_bank (
   input  logic                        rclk,
   input  logic                        rst_n,
   input  ifu_err_pkg::pc_t            pc_f,
   input  ifu_err_pkg::irf_err_t       irf_err_m,
   input  ifu_err_pkg::eaddr_t         lsu_err_addr,
   input  ifu_err_pkg::asi_data_t      asi_wr_data,
   input  ifu_err_pkg::eadr_sel_t      eadr_sel,
   output ifu_err_pkg::eaddr_t [ifu_err_pkg::num_threads-1:0] err_addr_all
);

   import ifu_err_pkg::*;

   eaddr_t   pc_s1;
   eaddr_t   pc_d1;
   irf_err_t irf_err_w;
   eaddr_t   lsu_err_w;
   eaddr_t   irf_fmt;
   eaddr_t   asi_wr_addr;

   // --------------------------------------------------
   // source staging
   // --------------------------------------------------
   // pc goes through s1 and d1 before it reaches the mux
   always_ff @(posedge rclk) begin
      pc_s1 <= pc_f[47:4];
      pc_d1 <= pc_s1;
   end

   // irf and lsu errors arrive one stage early
   always_ff @(posedge rclk) begin
      irf_err_w <= irf_err_m;
      lsu_err_w <= lsu_err_addr;
   end

   // syndrome in 19..12, register number in 7..0
   assign irf_fmt = {24'b0, irf_err_w.synd, 4'b0, irf_err_w.rnum};

   assign asi_wr_addr = asi_wr_data[47:4];

   // --------------------------------------------------
   // per-thread error address registers
   // --------------------------------------------------
   for (genvar t = 0; t < num_threads; t++) begin : g_thr
      eaddr_t eadr_nxt;

      always_comb begin
         case (eadr_sel[t])
            EADR_IRF:    eadr_nxt = irf_fmt;
            EADR_LSU:    eadr_nxt = lsu_err_w;
            EADR_PC:     eadr_nxt = pc_d1;
            EADR_ASI_WR: eadr_nxt = asi_wr_addr;
            default:     eadr_nxt = err_addr_all[t];
         endcase
      end

      always_ff @(posedge rclk) begin
         if (!rst_n) begin
            err_addr_all[t] <= '0;
         end
         else begin
            err_addr_all[t] <= eadr_nxt;
         end
      end

      // the error control block only drives defined source codes
      a_eadr_sel_legal: assert property (
         @(posedge rclk) disable iff (!rst_n)
         eadr_sel[t] inside {EADR_HOLD, EADR_IRF, EADR_LSU, EADR_PC, EADR_ASI_WR}
      ) else $error("illegal error address source on thread %0d", t);
   end

endmodule

`default_nettype wire

// File: ifu_err_asi_read.sv
// Instruction mask register, registered ASI read-back mux and the
// parity checks on the fetched and next instruction words.
`default_nettype none
`timescale 1ns/10ps

module ifu_err_asi_read (
   input  logic                               rclk,
   input  logic                               rst_n,
   input  ifu_err_pkg::ic_tags_t              tags_s1,
   input  logic [ifu_err_pkg::num_ways-1:0]   valid_s1,
   input  ifu_err_pkg::eaddr_t [ifu_err_pkg::num_threads-1:0] err_addr_all,
   input  ifu_err_pkg::err_regs_t             err_regs,
   input  ifu_err_pkg::inst_t                 fet_inst,
   input  ifu_err_pkg::inst_t                 top_inst,
   input  ifu_err_pkg::asi_data_t             asi_wr_data,
   input  logic                               ld_imask,
   input  ifu_err_pkg::asi_rd_sel_t           asi_rd_sel,
   output ifu_err_pkg::imask_t                imask,
   output ifu_err_pkg::asi_data_t             ldxa_data,
   output logic                               fet_pe,
   output logic                               top_pe
);

   import ifu_err_pkg::*;

   ic_way_tag_t way_tag;
   logic        way_valid;
   asi_data_t   ldxa_nxt;

   // --------------------------------------------------
   // instruction parity
   // --------------------------------------------------
   assign fet_pe = ^fet_inst;
   assign top_pe = ^top_inst;

   // instruction mask loaded by asi write
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         imask <= '0;
      end
      else if (ld_imask) begin
         imask <= asi_wr_data[38:0];
      end
   end

   // --------------------------------------------------
   // read-back mux
   // --------------------------------------------------
   assign way_tag   = tags_s1[asi_rd_sel.way];
   assign way_valid = valid_s1[asi_rd_sel.way];

   always_comb begin
      case (asi_rd_sel.src)
         ASI_ERR_EN:   ldxa_nxt = {62'b0, err_regs.enable};
         ASI_ERR_STAT: ldxa_nxt = {32'b0, err_regs.status, 9'b0};
         ASI_ERR_INJ:  ldxa_nxt = {32'b0, err_regs.inject};
         ASI_ERR_ADDR: ldxa_nxt = {16'b0, err_addr_all[asi_rd_sel.thr], 4'b0};
         // valid at 31, parity at 29, tag in 27..0
         ASI_IC_TAG: begin
            ldxa_nxt = {32'b0, way_valid, 1'b0, way_tag.par, 1'b0, way_tag.tag};
         end
         ASI_IMASK:    ldxa_nxt = {25'b0, imask};
         // parity bit moves to the top of the returned word
         ASI_IC_DATA:  ldxa_nxt = {30'b0, fet_inst[0], fet_inst[33:1]};
         default:      ldxa_nxt = '0;
      endcase
   end

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         ldxa_data <= '0;
      end
      else begin
         ldxa_data <= ldxa_nxt;
      end
   end

   a_none_reads_zero: assert property (
      @(posedge rclk) disable iff (!rst_n)
      asi_rd_sel.src == ASI_NONE |=> ldxa_data == '0
   ) else $error("ldxa data not zero after an empty asi read");

endmodule

`default_nettype wire

// File: ifu_err_dp.sv
// Top level of the IFU error datapath, tag check, error address
// bank and ASI read-back wired together.
`default_nettype none
`timescale 1ns/10ps

module ifu_err_dp (
   input  logic                               rclk,
   input  logic                               rst_n,
   input  ifu_err_pkg::ic_tags_t              ic_tags,
   input  logic [ifu_err_pkg::num_ways-1:0]   ic_valid,
   input  ifu_err_pkg::inst_t                 fet_inst,
   input  ifu_err_pkg::inst_t                 top_inst,
   input  ifu_err_pkg::pc_t                   pc_f,
   input  ifu_err_pkg::irf_err_t              irf_err_m,
   input  ifu_err_pkg::eaddr_t                lsu_err_addr,
   input  ifu_err_pkg::asi_data_t             asi_wr_data,
   input  ifu_err_pkg::eadr_sel_t             eadr_sel,
   input  logic                               ld_imask,
   input  ifu_err_pkg::asi_rd_sel_t           asi_rd_sel,
   input  ifu_err_pkg::err_regs_t             err_regs,
   output logic [ifu_err_pkg::num_ways-1:0]   tag_pe,
   output logic                               fet_pe,
   output logic                               top_pe,
   output ifu_err_pkg::imask_t                imask,
   output ifu_err_pkg::asi_data_t             ldxa_data
);

   import ifu_err_pkg::*;

   ic_tags_t                   tags_s1;
   logic [num_ways-1:0]        valid_s1;
   eaddr_t [num_threads-1:0]   err_addr_all;

   ifu_err_tag_check tag_chk0 (
      .rclk     (rclk),
      .rst_n    (rst_n),
      .ic_tags  (ic_tags),
      .ic_valid (ic_valid),
      .tags_s1  (tags_s1),
      .valid_s1 (valid_s1),
      .tag_pe   (tag_pe)
   );

   ifu_err_addr_bank addr_bank0 (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .pc_f         (pc_f),
      .irf_err_m    (irf_err_m),
      .lsu_err_addr (lsu_err_addr),
      .asi_wr_data  (asi_wr_data),
      .eadr_sel     (eadr_sel),
      .err_addr_all (err_addr_all)
   );

   ifu_err_asi_read asi_rd0 (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .tags_s1      (tags_s1),
      .valid_s1     (valid_s1),
      .err_addr_all (err_addr_all),
      .err_regs     (err_regs),
      .fet_inst     (fet_inst),
      .top_inst     (top_inst),
      .asi_wr_data  (asi_wr_data),
      .ld_imask     (ld_imask),
      .asi_rd_sel   (asi_rd_sel),
      .imask        (imask),
      .ldxa_data    (ldxa_data),
      .fet_pe       (fet_pe),
      .top_pe       (top_pe)
   );

endmodule

`default_nettype wire

// File: ifu_err_pkg.sv
// Shared widths, enums and packed structs for the IFU error datapath.
// Import into a module body, or use scoped names in port lists.
`default_nettype none

package ifu_err_pkg;

   // --------------------------------------------------
   // sizes
   // --------------------------------------------------
   localparam int num_threads = 4;
   localparam int thread_w    = 2;
   localparam int num_ways    = 4;
   localparam int way_w       = 2;
   localparam int ic_tag_w    = 28;

   // address bits 47..4 with the low nibble implied
   typedef logic [47:4] eaddr_t;
   typedef logic [47:0] pc_t;
   // 32-bit instruction plus predecode and parity
   typedef logic [33:0] inst_t;
   typedef logic [63:0] asi_data_t;
   typedef logic [38:0] imask_t;

   // --------------------------------------------------
   // cache tags
   // --------------------------------------------------
   typedef struct packed {
      logic                par;
      logic [ic_tag_w-1:0] tag;
   } ic_way_tag_t;

   typedef ic_way_tag_t [num_ways-1:0] ic_tags_t;

   // integer register file ecc error from the m stage
   typedef struct packed {
      logic [7:0] rnum;
      logic [7:0] synd;
   } irf_err_t;

   // per-thread error address source
   typedef enum logic [2:0] {
      EADR_HOLD   = 3'd0,
      EADR_IRF    = 3'd1,
      EADR_LSU    = 3'd2,
      EADR_PC     = 3'd3,
      EADR_ASI_WR = 3'd4
   } eadr_src_e;

   typedef eadr_src_e [num_threads-1:0] eadr_sel_t;

   // --------------------------------------------------
   // asi read-back
   // --------------------------------------------------
   typedef enum logic [2:0] {
      ASI_ERR_EN   = 3'd0,
      ASI_ERR_STAT = 3'd1,
      ASI_ERR_INJ  = 3'd2,
      ASI_ERR_ADDR = 3'd3,
      ASI_IC_TAG   = 3'd4,
      ASI_IMASK    = 3'd5,
      ASI_IC_DATA  = 3'd6,
      ASI_NONE     = 3'd7
   } asi_src_e;

   typedef struct packed {
      asi_src_e            src;
      logic [thread_w-1:0] thr;
      logic [way_w-1:0]    way;
   } asi_rd_sel_t;

   // error control register fields owned by the error control block
   typedef struct packed {
      logic [1:0]  enable;
      logic [22:0] status;
      logic [31:0] inject;
   } err_regs_t;

endpackage

`default_nettype wire

// File: ifu_err_tag_check.sv
// Stages the instruction cache tags and valid bits by one cycle and
// flags a parity error per way on the staged tags.
`default_nettype none
`timescale 1ns/10ps

module ifu_err_tag_check (
   input  logic                               rclk,
   input  logic                               rst_n,
   input  ifu_err_pkg::ic_tags_t              ic_tags,
   input  logic [ifu_err_pkg::num_ways-1:0]   ic_valid,
   output ifu_err_pkg::ic_tags_t              tags_s1,
   output logic [ifu_err_pkg::num_ways-1:0]   valid_s1,
   output logic [ifu_err_pkg::num_ways-1:0]   tag_pe
);

   import ifu_err_pkg::*;

   // --------------------------------------------------
   // f to s1 staging
   // --------------------------------------------------
   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         tags_s1  <= '0;
         valid_s1 <= '0;
      end
      else begin
         tags_s1  <= ic_tags;
         valid_s1 <= ic_valid;
      end
   end

   // --------------------------------------------------
   // parity check
   // --------------------------------------------------
   // even parity over parity bit and tag, so a clean way gives 0
   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         tag_pe[w] = ^tags_s1[w];
      end
   end

   // known tags in one cycle must give a known error flag in the next
   a_tag_pe_known: assert property (
      @(posedge rclk) disable iff (!rst_n)
      !$isunknown($past(ic_tags)) |-> !$isunknown(tag_pe)
   ) else $error("tag parity flags unknown after known tags");

endmodule

`default_nettype wire

// File: tb_ifu_err_dp.sv
// Directed testbench for the IFU error datapath top level.
// Each test drives the DUT at the clock edge and checks the response.
`default_nettype none
`timescale 1ns/10ps

module tb_ifu_err_dp;

   import ifu_err_pkg::*;

   logic rclk, rst_n, ld_imask, fet_pe, top_pe;
   ic_tags_t ic_tags;
   logic [num_ways-1:0] ic_valid, tag_pe;
   inst_t fet_inst, top_inst;
   pc_t pc_f;
   irf_err_t irf_err_m;
   eaddr_t lsu_err_addr;
   asi_data_t asi_wr_data, ldxa_data;
   eadr_sel_t eadr_sel;
   asi_rd_sel_t asi_rd_sel;
   err_regs_t err_regs;
   imask_t imask;
   int errors, tests_run, tests_failed, start_err;

   ifu_err_dp dut0 (.*);

   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;
   end

   // run limit for the whole simulation
   initial begin
      #200000;
      $display("timeout, the run did not finish in time");
      $display("Some tests failed");
      $finish;
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic cycles(input int n);
      for (int i = 0; i < n; i++) @(posedge rclk);
      #1;
   endtask

   // one registered read sampled just after the capturing edge
   task automatic asi_read(input asi_src_e src, input int thr, input int way,
                           output logic [63:0] data);
      @(posedge rclk);
      asi_rd_sel.src <= src;
      asi_rd_sel.thr <= thr[thread_w-1:0];
      asi_rd_sel.way <= way[way_w-1:0];
      cycles(1);
      data = ldxa_data;
   endtask

   task automatic all_hold();
      for (int t = 0; t < num_threads; t++) eadr_sel[t] <= EADR_HOLD;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != start_err) tests_failed++;
      $display("test %s: %s", name, (errors == start_err) ? "ok" : "errors");
      start_err = errors;
   endtask

   task automatic test_reset();
      logic [63:0] d;
      check("imask", imask, 0);
      check("ldxa_data", ldxa_data, 0);
      for (int t = 0; t < num_threads; t++) begin
         asi_read(ASI_ERR_ADDR, t, 0, d);
         check("ldxa_data", d, 0);
      end
      finish_test("reset");
   endtask

   task automatic test_tags();
      logic [63:0] d, e;
      ic_tags_t tv;
      logic [num_ways-1:0] vv;
      int bad;
      bad = $urandom % num_ways;
      vv = $urandom;
      for (int w = 0; w < num_ways; w++) begin
         tv[w].tag = $urandom;
         tv[w].par = ^tv[w].tag ^ (w == bad);
      end
      @(posedge rclk);
      ic_tags <= tv;
      ic_valid <= vv;
      cycles(1);
      for (int w = 0; w < num_ways; w++) begin
         check("tag_pe", tag_pe[w], ^tv[w]);
         check("tag_pe bad way", tag_pe[w], w == bad);
      end
      for (int w = 0; w < num_ways; w++) begin
         asi_read(ASI_IC_TAG, 0, w, d);
         e = 0;
         e[31] = vv[w];
         e[29] = tv[w].par;
         e[27:0] = tv[w].tag;
         check("ldxa_data", d, e);
      end
      finish_test("tag_parity");
   endtask

   task automatic test_inst();
      logic [63:0] d, e;
      inst_t fv;
      inst_t tv;
      for (int i = 0; i < 8; i++) begin
         fv = {$urandom, $urandom};
         tv = ~fv ^ {$urandom, 2'b01};
         @(posedge rclk);
         fet_inst <= fv;
         top_inst <= tv;
         cycles(1);
         check("fet_pe", fet_pe, ^fv);
         check("top_pe", top_pe, ^tv);
         asi_read(ASI_IC_DATA, 0, 0, d);
         e = 0;
         e[33] = fv[0];
         e[32:0] = fv[33:1];
         check("ldxa_data", d, e);
      end
      finish_test("inst_parity");
   endtask

   task automatic test_eaddr();
      logic [63:0] d;
      logic [63:0] exp [num_threads];
      logic [43:0] f;
      pc_t pcv;
      asi_data_t aw;
      irf_err_t iv;
      eaddr_t lv;
      pcv = {$urandom, $urandom};
      aw = {$urandom, $urandom};
      iv = $urandom;
      lv = {$urandom, $urandom};
      // irf and lsu on threads 0 and 1 with one stage of delay
      @(posedge rclk);
      irf_err_m <= iv;
      lsu_err_addr <= lv;
      @(posedge rclk);
      irf_err_m <= ~iv;
      lsu_err_addr <= ~lv;
      eadr_sel[0] <= EADR_LSU;
      eadr_sel[1] <= EADR_IRF;
      @(posedge rclk);
      all_hold();
      f = 0;
      f[19:12] = iv.synd;
      f[7:0] = iv.rnum;
      exp[0] = {16'b0, lv, 4'b0};
      exp[1] = {16'b0, f, 4'b0};
      exp[2] = 0;
      exp[3] = 0;
      for (int t = 0; t < num_threads; t++) begin
         asi_read(ASI_ERR_ADDR, t, 0, d);
         check("ldxa_data", d, exp[t]);
      end
      // pc on thread 2 after two stages and asi write data on thread 3
      @(posedge rclk);
      pc_f <= pcv;
      @(posedge rclk);
      pc_f <= ~pcv;
      @(posedge rclk);
      eadr_sel[2] <= EADR_PC;
      eadr_sel[3] <= EADR_ASI_WR;
      asi_wr_data <= aw;
      @(posedge rclk);
      all_hold();
      asi_wr_data <= ~aw;
      exp[2] = {16'b0, pcv[47:4], 4'b0};
      exp[3] = {16'b0, aw[47:4], 4'b0};
      for (int t = 0; t < num_threads; t++) begin
         asi_read(ASI_ERR_ADDR, t, 0, d);
         check("ldxa_data", d, exp[t]);
      end
      finish_test("error_address");
   endtask

   task automatic test_imask();
      logic [63:0] d;
      asi_data_t v;
      v = {$urandom, $urandom};
      @(posedge rclk);
      ld_imask <= 1'b1;
      asi_wr_data <= v;
      @(posedge rclk);
      ld_imask <= 1'b0;
      asi_wr_data <= ~v;
      #1;
      check("imask", imask, v[38:0]);
      cycles(3);
      check("imask", imask, v[38:0]);
      asi_read(ASI_IMASK, 0, 0, d);
      check("ldxa_data", d, {25'b0, v[38:0]});
      finish_test("imask");
   endtask

   task automatic test_err_regs();
      logic [63:0] d, e;
      err_regs_t r;
      r = {$urandom, $urandom};
      @(posedge rclk);
      err_regs <= r;
      asi_read(ASI_ERR_EN, 0, 0, d);
      check("ldxa_data", d, {62'b0, r.enable});
      asi_read(ASI_ERR_STAT, 0, 0, d);
      e = 0;
      e[31:9] = r.status;
      check("ldxa_data", d, e);
      asi_read(ASI_ERR_INJ, 0, 0, d);
      check("ldxa_data", d, {32'b0, r.inject});
      asi_read(ASI_NONE, 0, 0, d);
      check("ldxa_data", d, 0);
      finish_test("err_regs");
   endtask

   initial begin
      void'($urandom(51));
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      start_err = 0;
      rst_n = 1'b0;
      ld_imask = 1'b0;
      ic_tags = '0;
      ic_valid = '0;
      fet_inst = '0;
      top_inst = '0;
      pc_f = '0;
      irf_err_m = '0;
      lsu_err_addr = '0;
      asi_wr_data = '0;
      for (int t = 0; t < num_threads; t++) eadr_sel[t] = EADR_HOLD;
      asi_rd_sel.src = ASI_NONE;
      asi_rd_sel.thr = '0;
      asi_rd_sel.way = '0;
      err_regs = '0;
      repeat (3) @(posedge rclk);
      rst_n <= 1'b1;
      cycles(1);
      test_reset();
      test_tags();
      test_inst();
      test_eaddr();
      test_imask();
      test_err_regs();
      $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end
      else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
